// ==== filelist.f ====
rtl/cache_pkg.sv
rtl/cache_tag_store.sv
rtl/cache_data_store.sv
rtl/cache_ctrl.sv
rtl/data_memory.sv
rtl/cache.sv
testbench/cache_assert.sv
testbench/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
rm -f sim.log
verilator --binary --assert -f filelist.f --top-module cache_tb -o cache_sim &&
  ./obj_dir/cache_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '\*\*\* FAILED \*\*\*' sim.log 2>/dev/null && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log 2>/dev/null || exit 1

// ==== testbench/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb;

  localparam int TIMEOUT = 200;

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic [31:0] addr;
  logic        write;
  logic [31:0] din;
  logic        ready;
  logic        out_valid;
  logic [31:0] dout;
  logic        hit;
  integer      seed;

  cache u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Any assertion in the bound checker ends the run
  always @(posedge clk) begin
    if (u_dut.u_chk.fail_seen) begin
      $display("*** FAILED ***");
      $fatal(1, "assertion failure in bound checker");
    end
  end

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("*** FAILED ***");
    $fatal(1, "wait timed out");
  endtask

  // One load or store, returns in the cycle that shows out_valid
  task automatic access(input logic [31:0] a, input logic w, input logic [31:0] d);
    int n;
    n = 0;
    @(negedge clk);  // Outputs settled mid cycle
    while (!ready) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("ready");
    end
    @(posedge clk);
    in_valid <= 1'b1;
    addr     <= a;
    write    <= w;
    din      <= d;
    @(posedge clk);
    in_valid <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!out_valid) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("out_valid");
    end
  endtask

  task automatic random_mix(input int count);
    integer r;
    int     line;
    for (int i = 0; i < count; i++) begin
      r    = $random(seed);
      line = int'($unsigned(r) % 32'd24);  // 24 lines over 8 sets
      access(32'(line * 16) | {28'd0, r[5:4], 2'b00}, r[8], $random(seed));
    end
  endtask

  initial begin
    seed     = 68;
    reset    = 1'b1;
    in_valid = 1'b0;
    addr     = '0;
    write    = 1'b0;
    din      = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    access(32'h040, 1'b0, '0);  // Read miss, then hits in the line
    access(32'h044, 1'b0, '0);
    access(32'h04c, 1'b0, '0);
    access(32'h048, 1'b1, 32'hdead_beef);
    access(32'h048, 1'b0, '0);
    access(32'h044, 1'b0, '0);
    access(32'h2c4, 1'b1, 32'h0bad_cafe);  // Store miss
    access(32'h2c4, 1'b0, '0);
    access(32'h2c8, 1'b0, '0);
    // Three tags in set 0
    access(32'h000, 1'b0, '0);
    access(32'h080, 1'b0, '0);
    access(32'h000, 1'b0, '0);
    access(32'h100, 1'b0, '0);
    access(32'h000, 1'b0, '0);
    access(32'h080, 1'b0, '0);
    // Dirty line pushed out by two new tags, then read back
    access(32'h104, 1'b1, 32'h1234_5678);
    access(32'h180, 1'b0, '0);
    access(32'h200, 1'b0, '0);
    access(32'h104, 1'b0, '0);
    random_mix(300);
    @(posedge clk);
    if (u_dut.u_chk.fail_seen) begin
      $display("*** FAILED ***");
      $fatal(1, "assertion failure in bound checker");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== testbench/cache_assert.sv ====
`timescale 1ns/10ps

module cache_assert #(
  parameter int NUM_SETS  = 8,
  parameter int MEM_LINES = 64,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::LINE_LSB - IDX_W
) (
  input logic        clk,
  input logic        reset,
  input logic        in_valid,
  input logic [31:0] addr,
  input logic        write,
  input logic [31:0] din,
  input logic        ready,
  input logic        out_valid,
  input logic [31:0] dout,
  input logic        hit
);

  logic [31:0]      shadow [MEM_LINES*4];  // Word view of backing memory
  logic [1:0]       m_valid [NUM_SETS];
  logic [TAG_W-1:0] m_tag [NUM_SETS][2];
  logic             m_lru [NUM_SETS];      // Most recently used way
  logic [31:0]      p_addr;
  logic             p_write;
  logic [31:0]      p_din;
  logic             p_hit;
  logic             p_way;
  logic [31:0]      exp_dout;
  logic [IDX_W-1:0] p_set;
  logic             vict;
  logic             upd_way;
  logic             look_hit;
  logic             look_way;
  logic             e_reset = 1'b0;
  logic             e_flow = 1'b0;
  logic             e_release = 1'b0;
  logic             e_lat = 1'b0;
  logic             e_dout = 1'b0;
  logic             e_hit = 1'b0;
  logic             fail_seen;

  function automatic logic [IDX_W-1:0] set_of(input logic [31:0] a);
    return a[cache_pkg::LINE_LSB +: IDX_W];
  endfunction

  function automatic logic [TAG_W-1:0] tag_of(input logic [31:0] a);
    return a[cache_pkg::ADDR_W-1 -: TAG_W];
  endfunction

  function automatic int word_of(input logic [31:0] a);
    return int'(a[31:2]) % (MEM_LINES * 4);  // Memory wraps on its depth
  endfunction

  initial begin
    for (int i = 0; i < MEM_LINES * 4; i++) begin
      shadow[i] = 32'(i);
    end
  end

  // Lookup of the address on the port
  always_comb begin
    look_hit = 1'b0;
    look_way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (m_valid[set_of(addr)][w] && m_tag[set_of(addr)][w] == tag_of(addr)) begin
        look_hit = 1'b1;
        look_way = 1'(w);
      end
    end
  end

  assign p_set     = set_of(p_addr);
  assign vict      = !m_valid[p_set][0] ? 1'b0 : (!m_valid[p_set][1] ? 1'b1 : !m_lru[p_set]);
  assign upd_way   = p_hit ? p_way : vict;
  assign fail_seen = e_reset | e_flow | e_release | e_lat | e_dout | e_hit;

  always @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        m_valid[s] <= '0;
        m_lru[s]   <= 1'b0;
      end
    end else begin
      if (in_valid && ready) begin
        p_addr   <= addr;
        p_write  <= write;
        p_din    <= din;
        p_hit    <= look_hit;
        p_way    <= look_way;
        exp_dout <= write ? din : shadow[word_of(addr)];
      end
      if (out_valid) begin  // Line now resident, way becomes MRU
        m_valid[p_set][upd_way] <= 1'b1;
        m_tag[p_set][upd_way]   <= tag_of(p_addr);
        m_lru[p_set]            <= upd_way;
        if (p_write) begin
          shadow[word_of(p_addr)] <= p_din;
        end
      end
    end
  end

  a_reset: assert property (@(posedge clk) $past(reset) |-> ready && !out_valid && !hit)
    else begin
      e_reset = 1'b1;
      $error("MISMATCH after reset ready=%h out_valid=%h hit=%h",
             $sampled(ready), $sampled(out_valid), $sampled(hit));
    end

  a_flow: assert property (@(posedge clk) disable iff (reset)
    (in_valid && ready) || (!ready && !out_valid) |=> !ready)
    else begin
      e_flow = 1'b1;
      $error("MISMATCH ready=%h while a request is in flight", $sampled(ready));
    end

  a_release: assert property (@(posedge clk) disable iff (reset) out_valid |=> ready)
    else begin
      e_release = 1'b1;
      $error("MISMATCH ready=%h expected 1 after out_valid", $sampled(ready));
    end

  // Hit answers in COMPARE, one cycle after acceptance
  a_lat: assert property (@(posedge clk) disable iff (reset)
    in_valid && ready && look_hit |=> out_valid && hit)
    else begin
      e_lat = 1'b1;
      $error("MISMATCH out_valid=%h hit=%h expected 1 1", $sampled(out_valid), $sampled(hit));
    end

  a_dout: assert property (@(posedge clk) disable iff (reset) out_valid |-> dout == exp_dout)
    else begin
      e_dout = 1'b1;
      $error("MISMATCH dout got %h expected %h", $sampled(dout), $sampled(exp_dout));
    end

  a_hit: assert property (@(posedge clk) disable iff (reset) out_valid |-> hit == p_hit)
    else begin
      e_hit = 1'b1;
      $error("MISMATCH hit got %h expected %h", $sampled(hit), $sampled(p_hit));
    end

endmodule

bind cache cache_assert #(
  .NUM_SETS  (NUM_SETS),
  .MEM_LINES (MEM_LINES)
) u_chk (.*);

// ==== rtl/cache.sv ====
`timescale 1ns/10ps

module cache #(
  parameter int NUM_SETS  = 8,
  parameter int MEM_DELAY = 4,
  parameter int MEM_LINES = 64,
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::LINE_LSB - $clog2(NUM_SETS)
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  logic [cache_pkg::ADDR_W-1:0] addr,
  input  logic                         write,
  input  logic [cache_pkg::WORD_W-1:0] din,
  output logic                         ready,
  output logic                         out_valid,
  output logic [cache_pkg::WORD_W-1:0] dout,
  output logic                         hit
);

  cache_pkg::cache_req_t        req;
  cache_pkg::mem_req_t          mem_req;
  logic                         way_hit;
  logic                         hit_way;
  logic                         victim_way;
  logic                         victim_dirty;
  logic [TAG_W-1:0]             victim_tag;
  logic                         touch;
  logic                         mark_dirty;  // Also the data store's write strobe
  logic                         fill;
  logic                         way_sel;
  logic [cache_pkg::LINE_W-1:0] victim_line;
  logic                         mem_valid;
  logic                         mem_ready;
  logic                         mem_rvalid;
  logic [cache_pkg::LINE_W-1:0] mem_rdata;

  cache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .addr         (addr),
    .write        (write),
    .din          (din),
    .ready        (ready),
    .out_valid    (out_valid),
    .hit          (hit),
    .req          (req),
    .way_hit      (way_hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .touch        (touch),
    .mark_dirty   (mark_dirty),
    .fill         (fill),
    .way_sel      (way_sel),
    .victim_line  (victim_line),
    .mem_valid    (mem_valid),
    .mem_req      (mem_req),
    .mem_ready    (mem_ready),
    .mem_rvalid   (mem_rvalid)
  );

  cache_tag_store #(.NUM_SETS(NUM_SETS)) u_tags (
    .clk          (clk),
    .reset        (reset),
    .addr         (req.addr),
    .touch        (touch),
    .mark_dirty   (mark_dirty),
    .fill         (fill),
    .way          (way_sel),
    .way_hit      (way_hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  cache_data_store #(.NUM_SETS(NUM_SETS)) u_data (
    .clk       (clk),
    .addr      (req.addr),
    .way       (way_sel),
    .store     (mark_dirty),
    .din       (req.din),
    .fill      (fill),
    .fill_line (mem_rdata),
    .line      (victim_line),
    .dout      (dout)
  );

  data_memory #(
    .MEM_DELAY (MEM_DELAY),
    .MEM_LINES (MEM_LINES)
  ) u_mem (
    .clk        (clk),
    .reset      (reset),
    .mem_valid  (mem_valid),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

endmodule

// ==== rtl/data_memory.sv ====
`timescale 1ns/10ps

module data_memory #(
  parameter int MEM_DELAY = 4,
  parameter int MEM_LINES = 64,
  localparam int CNT_W  = $clog2(MEM_DELAY + 1),
  localparam int MIDX_W = $clog2(MEM_LINES)
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         mem_valid,
  input  cache_pkg::mem_req_t          mem_req,
  output logic                         mem_ready,
  output logic                         mem_rvalid,
  output logic [cache_pkg::LINE_W-1:0] mem_rdata
);

  logic [cache_pkg::LINE_W-1:0] lines [MEM_LINES];
  logic [CNT_W-1:0]             count_q;       // Busy cycles left
  logic                         rd_pending_q;
  logic [MIDX_W-1:0]            rd_idx_q;
  logic [MIDX_W-1:0]            req_idx;
  logic                         accept;
  logic                         expire;

  assign req_idx   = MIDX_W'(mem_req.line_addr % MEM_LINES);
  assign mem_ready = (count_q == '0);
  assign accept    = mem_valid && mem_ready;
  assign expire    = rd_pending_q && (count_q == CNT_W'(1));  // Last busy cycle

  // Every word holds its own word address
  initial begin
    for (int l = 0; l < MEM_LINES; l++) begin
      for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
        lines[l][w*cache_pkg::WORD_W +: cache_pkg::WORD_W] = l * cache_pkg::LINE_WORDS + w;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q      <= '0;
      rd_pending_q <= 1'b0;
      mem_rvalid   <= 1'b0;
    end else begin
      mem_rvalid <= expire;  // Lands with mem_ready back high
      if (accept) begin
        count_q      <= CNT_W'(MEM_DELAY);
        rd_pending_q <= (mem_req.op == cache_pkg::MEM_READ);
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
        if (expire) begin
          rd_pending_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rd_idx_q <= req_idx;
    end
    if (expire) begin
      mem_rdata <= lines[rd_idx_q];
    end
  end

  // Writes land at acceptance
  always @(posedge clk) begin
    if (accept && mem_req.op == cache_pkg::MEM_WRITE) begin
      lines[req_idx] <= mem_req.data;
    end
  end

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl #(
  parameter int NUM_SETS = 8,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::LINE_LSB - IDX_W,
  localparam int PAD_W = cache_pkg::LADDR_W - (cache_pkg::ADDR_W - cache_pkg::LINE_LSB)
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  logic [cache_pkg::ADDR_W-1:0] addr,
  input  logic                         write,
  input  logic [cache_pkg::WORD_W-1:0] din,
  output logic                         ready,
  output logic                         out_valid,
  output logic                         hit,
  output cache_pkg::cache_req_t        req,
  input  logic                         way_hit,
  input  logic                         hit_way,
  input  logic                         victim_way,
  input  logic                         victim_dirty,
  input  logic [TAG_W-1:0]             victim_tag,
  output logic                         touch,
  output logic                         mark_dirty,
  output logic                         fill,
  output logic                         way_sel,
  input  logic [cache_pkg::LINE_W-1:0] victim_line,
  output logic                         mem_valid,
  output cache_pkg::mem_req_t          mem_req,
  input  logic                         mem_ready,
  input  logic                         mem_rvalid
);

  cache_pkg::cache_state_e state_q;
  cache_pkg::cache_state_e state_d;
  logic                    missed_q;  // Any miss during this request
  logic                    victim_q;
  logic                    accept;
  logic [IDX_W-1:0]        idx;

  assign idx    = req.addr[cache_pkg::LINE_LSB +: IDX_W];
  assign ready  = (state_q == cache_pkg::IDLE);
  assign accept = ready && in_valid;

  assign out_valid  = (state_q == cache_pkg::COMPARE) && way_hit;
  assign hit        = out_valid && !missed_q;
  assign touch      = out_valid;
  assign mark_dirty = out_valid && req.write;
  assign fill       = (state_q == cache_pkg::ALLOC_WAIT) && mem_rvalid;
  assign way_sel    = (state_q == cache_pkg::COMPARE) ? hit_way : victim_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::IDLE: if (in_valid) state_d = cache_pkg::COMPARE;
      cache_pkg::COMPARE: begin
        if (way_hit) begin
          state_d = cache_pkg::IDLE;
        end else if (victim_dirty) begin
          state_d = cache_pkg::WRITE_BACK;
        end else begin
          state_d = cache_pkg::ALLOCATE;
        end
      end
      cache_pkg::WRITE_BACK: if (mem_ready) state_d = cache_pkg::WB_WAIT;
      cache_pkg::WB_WAIT:    if (mem_ready) state_d = cache_pkg::ALLOCATE;
      cache_pkg::ALLOCATE:   if (mem_ready) state_d = cache_pkg::ALLOC_WAIT;
      cache_pkg::ALLOC_WAIT: if (mem_rvalid) state_d = cache_pkg::COMPARE;  // Retry as hit
      default:               state_d = cache_pkg::IDLE;
    endcase
  end

  assign mem_valid = mem_ready &&
                     (state_q == cache_pkg::WRITE_BACK || state_q == cache_pkg::ALLOCATE);

  // Write-back goes to the victim's own line, fetch to the request's line
  always_comb begin
    mem_req.op        = cache_pkg::MEM_READ;
    mem_req.line_addr = {{PAD_W{1'b0}}, req.addr[cache_pkg::ADDR_W-1:cache_pkg::LINE_LSB]};
    mem_req.data      = victim_line;
    if (state_q == cache_pkg::WRITE_BACK) begin
      mem_req.op        = cache_pkg::MEM_WRITE;
      mem_req.line_addr = {{PAD_W{1'b0}}, victim_tag, idx};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= cache_pkg::IDLE;
      missed_q <= 1'b0;
      victim_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        missed_q <= 1'b0;
      end else if (state_q == cache_pkg::COMPARE && !way_hit) begin
        missed_q <= 1'b1;
        victim_q <= victim_way;  // Frozen until the fill
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req.addr  <= addr;
      req.write <= write;
      req.din   <= din;
    end
  end

endmodule

// ==== rtl/cache_data_store.sv ====
`timescale 1ns/10ps

module cache_data_store #(
  parameter int NUM_SETS = 8,
  localparam int IDX_W = $clog2(NUM_SETS)
) (
  input  logic                         clk,
  input  logic [cache_pkg::ADDR_W-1:0] addr,
  input  logic                         way,
  input  logic                         store,
  input  logic [cache_pkg::WORD_W-1:0] din,
  input  logic                         fill,
  input  logic [cache_pkg::LINE_W-1:0] fill_line,
  output logic [cache_pkg::LINE_W-1:0] line,
  output logic [cache_pkg::WORD_W-1:0] dout
);

  logic [cache_pkg::LINE_W-1:0]   data_q [NUM_SETS][2];
  logic [IDX_W-1:0]               idx;
  logic [cache_pkg::OFFSET_W-1:0] offset;
  logic [cache_pkg::LINE_W-1:0]   merged;

  assign idx    = addr[cache_pkg::LINE_LSB +: IDX_W];
  assign offset = addr[cache_pkg::BYTE_OFF_W +: cache_pkg::OFFSET_W];
  assign line   = data_q[idx][way];

  // Store word dropped into the current line
  always_comb begin
    merged = line;
    merged[offset*cache_pkg::WORD_W +: cache_pkg::WORD_W] = din;
  end

  // A store shows its own word, as the array only changes at the edge
  assign dout = store ? din : line[offset*cache_pkg::WORD_W +: cache_pkg::WORD_W];

  always_ff @(posedge clk) begin
    if (fill) begin
      data_q[idx][way] <= fill_line;
    end else if (store) begin
      data_q[idx][way] <= merged;
    end
  end

endmodule

// ==== rtl/cache_tag_store.sv ====
`timescale 1ns/10ps

module cache_tag_store #(
  parameter int NUM_SETS = 8,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::LINE_LSB - IDX_W
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [cache_pkg::ADDR_W-1:0] addr,
  input  logic                         touch,
  input  logic                         mark_dirty,
  input  logic                         fill,
  input  logic                         way,
  output logic                         way_hit,
  output logic                         hit_way,
  output logic                         victim_way,
  output logic                         victim_dirty,
  output logic [TAG_W-1:0]             victim_tag
);

  logic [IDX_W-1:0]    idx;
  logic [TAG_W-1:0]    tag;
  logic [1:0]          match;
  logic [1:0]          valid_q [NUM_SETS];
  logic [1:0]          dirty_q [NUM_SETS];
  logic [NUM_SETS-1:0] lru_q;                 // Most recently used way per set
  logic [TAG_W-1:0]    tag_q   [NUM_SETS][2];

  assign idx = addr[cache_pkg::LINE_LSB +: IDX_W];
  assign tag = addr[cache_pkg::ADDR_W-1 -: TAG_W];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      match[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
    end
  end

  assign way_hit = |match;
  assign hit_way = match[1];  // Tags in a set are distinct

  // Empty way first, lower one wins
  always_comb begin
    if (!valid_q[idx][0]) begin
      victim_way = 1'b0;
    end else if (!valid_q[idx][1]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = ~lru_q[idx];
    end
  end

  assign victim_dirty = valid_q[idx][victim_way] && dirty_q[idx][victim_way];
  assign victim_tag   = tag_q[idx][victim_way];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
      lru_q <= '0;
    end else begin
      if (touch) begin
        lru_q[idx] <= way;
      end
      if (mark_dirty) begin
        dirty_q[idx][way] <= 1'b1;
      end
      if (fill) begin
        valid_q[idx][way] <= 1'b1;  // New line arrives clean
        dirty_q[idx][way] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[idx][way] <= tag;
    end
  end

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

  localparam int WORD_W     = 32;
  localparam int ADDR_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = WORD_W * LINE_WORDS;  // 128
  localparam int OFFSET_W   = $clog2(LINE_WORDS);   // Word within line
  localparam int BYTE_OFF_W = 2;                    // Ignored byte bits
  localparam int LINE_LSB   = BYTE_OFF_W + OFFSET_W;
  localparam int LADDR_W    = ADDR_W - BYTE_OFF_W;  // Line address field width

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRITE_BACK,
    WB_WAIT,
    ALLOCATE,
    ALLOC_WAIT
  } cache_state_e;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  // Processor request held for the whole access
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [WORD_W-1:0] din;
  } cache_req_t;

  typedef struct packed {
    mem_op_e            op;
    logic [LADDR_W-1:0] line_addr;  // Word address / 4
    logic [LINE_W-1:0]  data;
  } mem_req_t;

endpackage
